// ==== run_sim.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --assert --top-module tcp_stream_tb -f sources.f -o tcp_stream_sim \
    && ./obj_dir/tcp_stream_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

// ==== sources.f ====
tcp_pkg.sv
tcp_state_manager.sv
tcp_tx_ctrl.sv
tcp_packet_generator.sv
tcp_parser.sv
tcp_rx_ctrl.sv
tcp_stream.sv
tb_clk_gen.sv
tcp_stream_tb.sv

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter realtime P_PERIOD     = 8.0,
    parameter int      P_RST_CYCLES = 16
) (
    input  logic i_rst_req,
    output logic o_clk,
    output logic o_rst
);

    int rst_cnt;

    initial begin
        o_clk   = 1'b0;
        o_rst   = 1'b1;
        rst_cnt = 0;
    end

    always #(P_PERIOD / 2) o_clk = ~o_clk;

    // a request restarts the full reset window
    always @(posedge o_clk) begin
        if (i_rst_req) begin
            o_rst   <= 1'b1;
            rst_cnt <= 0;
        end else if (o_rst) begin
            if (rst_cnt == P_RST_CYCLES - 1) begin
                o_rst <= 1'b0;
            end
            rst_cnt <= rst_cnt + 1;
        end
    end

endmodule

// ==== tcp_packet_generator.sv ====
`timescale 1ns/1ps

module tcp_packet_generator #(
    parameter tcp_pkg::window_t P_WINDOW = 16'hffff
) (
    input  logic                 i_clk,
    input  logic                 i_rst,

    input  tcp_pkg::conn_cfg_t   i_cfg,

    input  tcp_pkg::seq_num_t    i_seq_number,
    input  tcp_pkg::seq_num_t    i_ack_number,
    input  tcp_pkg::tcp_flags_t  i_flags,
    input  logic                 i_hdr_valid,

    output logic                 o_packet_done,

    output tcp_pkg::word_t       o_tx_data,
    output logic                 o_tx_valid,
    output logic                 o_tx_last,
    output tcp_pkg::ip_meta_t    o_tx_meta
);

    import tcp_pkg::*;

    localparam logic [2:0]  LAST_IDX    = 3'(HDR_WORDS - 1);
    localparam logic [3:0]  DATA_OFFSET = 4'(HDR_WORDS);
    localparam logic [15:0] SEG_LEN     = 16'(HDR_WORDS * 4);

    seq_num_t   seq_q;
    seq_num_t   ack_q;
    tcp_flags_t flags_q;
    logic [2:0] word_cnt;

    // latched per header
    always_ff @(posedge i_clk) begin
        if (i_hdr_valid) begin
            seq_q   <= i_seq_number;
            ack_q   <= ((i_flags & FLAG_ACK) != '0) ? i_ack_number : '0;
            flags_q <= i_flags;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_tx_valid <= 1'b0;
            word_cnt   <= '0;
        end else if (i_hdr_valid) begin
            o_tx_valid <= 1'b1;
            word_cnt   <= '0;
        end else if (o_tx_valid) begin
            if (o_tx_last) begin
                o_tx_valid <= 1'b0;
                word_cnt   <= '0;
            end else begin
                word_cnt <= word_cnt + 3'd1;
            end
        end
    end

    assign o_tx_last     = o_tx_valid && (word_cnt == LAST_IDX);
    assign o_packet_done = o_tx_last;

    always_comb begin
        case (word_cnt)
            3'd0:    o_tx_data = {i_cfg.src_port, i_cfg.dst_port};
            3'd1:    o_tx_data = seq_q;
            3'd2:    o_tx_data = ack_q;
            3'd3:    o_tx_data = {DATA_OFFSET, 4'd0, flags_q, P_WINDOW};
            // urgent pointer and checksum left at zero
            default: o_tx_data = '0;
        endcase
    end

    assign o_tx_meta = '{src_ip: i_cfg.src_ip, dst_ip: i_cfg.dst_ip, len: SEG_LEN};

endmodule

// ==== tcp_parser.sv ====
`timescale 1ns/1ps

module tcp_parser (
    input  logic                 i_clk,
    input  logic                 i_rst,

    input  tcp_pkg::conn_cfg_t   i_cfg,

    input  tcp_pkg::word_t       i_rx_data,
    input  logic                 i_rx_valid,
    input  logic                 i_rx_last,

    output tcp_pkg::seq_num_t    o_seq_number,
    output tcp_pkg::seq_num_t    o_ack_number,
    output tcp_pkg::tcp_flags_t  o_flags,
    output logic                 o_hdr_valid
);

    import tcp_pkg::*;

    localparam logic [2:0] LAST_IDX = 3'(HDR_WORDS - 1);

    logic [2:0] word_cnt;
    logic       port_ok;
    seq_num_t   seq_q;
    seq_num_t   ack_q;
    tcp_flags_t flags_q;

    // word count saturates so long segments never match
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            word_cnt    <= '0;
            o_hdr_valid <= 1'b0;
        end else begin
            o_hdr_valid <= 1'b0;
            if (i_rx_valid) begin
                if (i_rx_last) begin
                    word_cnt    <= '0;
                    o_hdr_valid <= (word_cnt == LAST_IDX) && port_ok;
                end else if (word_cnt != 3'd7) begin
                    word_cnt <= word_cnt + 3'd1;
                end
            end
        end
    end

    // peer src port is our remote and peer dst port is our local
    always_ff @(posedge i_clk) begin
        if (i_rx_valid) begin
            case (word_cnt)
                3'd0: port_ok <= (i_rx_data[31:16] == i_cfg.dst_port)
                              && (i_rx_data[15:0] == i_cfg.src_port);
                3'd1: seq_q   <= i_rx_data;
                3'd2: ack_q   <= i_rx_data;
                3'd3: flags_q <= i_rx_data[23:16];
                default: ;
            endcase
        end
    end

    assign o_seq_number = seq_q;
    assign o_ack_number = ack_q;
    assign o_flags      = flags_q;

endmodule

// ==== tcp_pkg.sv ====
package tcp_pkg;

    typedef logic [31:0] seq_num_t;
    typedef logic [15:0] port_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [7:0]  tcp_flags_t;
    typedef logic [15:0] window_t;
    typedef logic [31:0] word_t;

    // standard tcp flag bit positions
    localparam tcp_flags_t FLAG_FIN = 8'h01;
    localparam tcp_flags_t FLAG_SYN = 8'h02;
    localparam tcp_flags_t FLAG_RST = 8'h04;
    localparam tcp_flags_t FLAG_PSH = 8'h08;
    localparam tcp_flags_t FLAG_ACK = 8'h10;

    // 20-byte header, no options
    localparam int HDR_WORDS = 5;

    // local and remote endpoint
    typedef struct packed {
        ip_addr_t src_ip;
        ip_addr_t dst_ip;
        port_t    src_port;
        port_t    dst_port;
    } conn_cfg_t;

    // travels beside the tx word stream
    typedef struct packed {
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
        logic [15:0] len;
    } ip_meta_t;

    typedef struct packed {
        tcp_flags_t flags;
    } tx_ctrl_t;

    typedef struct packed {
        tcp_flags_t flags;
        seq_num_t   seq;
        seq_num_t   ack;
    } rx_msg_t;

    typedef enum logic [1:0] {
        ST_CLOSED      = 2'd0,
        ST_SYN_SENT    = 2'd1,
        ST_ESTABLISHED = 2'd2,
        ST_FIN_WAIT    = 2'd3
    } tcp_state_t;

endpackage

// ==== tcp_rx_ctrl.sv ====
`timescale 1ns/1ps

module tcp_rx_ctrl (
    input  logic                 i_clk,
    input  logic                 i_rst,

    input  tcp_pkg::seq_num_t    i_seq_number,
    input  tcp_pkg::seq_num_t    i_ack_number,
    input  tcp_pkg::tcp_flags_t  i_flags,
    input  logic                 i_hdr_valid,

    output tcp_pkg::rx_msg_t     o_rx_msg,
    output logic                 o_rx_msg_valid,
    input  logic                 i_rx_msg_ack,

    output tcp_pkg::seq_num_t    o_ack_number
);

    import tcp_pkg::*;

    seq_num_t rcv_nxt;
    logic     slot_free;
    logic     accept;
    logic     consumes_seq;

    // slot frees in the same cycle it is acked
    assign slot_free    = !o_rx_msg_valid || i_rx_msg_ack;
    assign accept       = i_hdr_valid && slot_free;
    assign consumes_seq = (i_flags & (FLAG_SYN | FLAG_FIN)) != '0;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rcv_nxt        <= '0;
            o_rx_msg_valid <= 1'b0;
        end else begin
            if (o_rx_msg_valid && i_rx_msg_ack) begin
                o_rx_msg_valid <= 1'b0;
            end
            if (accept) begin
                o_rx_msg_valid <= 1'b1;
                rcv_nxt        <= consumes_seq ? i_seq_number + 32'd1 : i_seq_number;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_rx_msg <= '{flags: i_flags, seq: i_seq_number, ack: i_ack_number};
        end
    end

    // feeds the ack field of outgoing headers
    assign o_ack_number = rcv_nxt;

endmodule

// ==== tcp_state_manager.sv ====
`timescale 1ns/1ps

module tcp_state_manager #(
    parameter tcp_pkg::seq_num_t P_ISS = 32'h0000_1000
) (
    input  logic                 i_clk,
    input  logic                 i_rst,

    input  logic                 i_enable,
    input  logic                 i_open,
    input  logic                 i_close,

    output tcp_pkg::tx_ctrl_t    o_tx_ctrl,
    output logic                 o_tx_ctrl_valid,
    input  logic                 i_tx_ctrl_ack,

    input  tcp_pkg::rx_msg_t     i_rx_msg,
    input  logic                 i_rx_msg_valid,
    output logic                 o_rx_msg_ack,

    output tcp_pkg::tcp_state_t  o_state
);

    import tcp_pkg::*;

    // peer must acknowledge our SYN, then our FIN
    localparam seq_num_t SYN_ACK_EXP = P_ISS + 32'd1;
    localparam seq_num_t FIN_ACK_EXP = P_ISS + 32'd2;

    localparam tcp_flags_t SYN_ACK = FLAG_SYN | FLAG_ACK;
    localparam tcp_flags_t FIN_ACK = FLAG_FIN | FLAG_ACK;

    logic msg_take;
    logic msg_rst;
    logic synack_ok;
    logic finack_ok;

    // a message is only consumed with no request outstanding
    assign msg_take     = i_rx_msg_valid && !o_tx_ctrl_valid;
    assign o_rx_msg_ack = msg_take;

    assign msg_rst   = (i_rx_msg.flags & FLAG_RST) != '0;
    assign synack_ok = ((i_rx_msg.flags & SYN_ACK) == SYN_ACK) && (i_rx_msg.ack == SYN_ACK_EXP);
    assign finack_ok = ((i_rx_msg.flags & FIN_ACK) == FIN_ACK) && (i_rx_msg.ack == FIN_ACK_EXP);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_state         <= ST_CLOSED;
            o_tx_ctrl_valid <= 1'b0;
            o_tx_ctrl       <= '0;
        end else begin
            if (o_tx_ctrl_valid && i_tx_ctrl_ack) begin
                o_tx_ctrl_valid <= 1'b0;
            end

            if (!i_enable) begin
                // abort drops any pending open
                o_state <= ST_CLOSED;
            end else if (msg_take && msg_rst) begin
                o_state <= ST_CLOSED;
            end else if (!o_tx_ctrl_valid) begin
                case (o_state)
                    ST_CLOSED: begin
                        if (i_open) begin
                            o_tx_ctrl.flags <= FLAG_SYN;
                            o_tx_ctrl_valid <= 1'b1;
                            o_state         <= ST_SYN_SENT;
                        end
                    end
                    ST_SYN_SENT: begin
                        if (i_rx_msg_valid && synack_ok) begin
                            o_tx_ctrl.flags <= FLAG_ACK;
                            o_tx_ctrl_valid <= 1'b1;
                            o_state         <= ST_ESTABLISHED;
                        end
                    end
                    ST_ESTABLISHED: begin
                        if (i_close) begin
                            o_tx_ctrl.flags <= FIN_ACK;
                            o_tx_ctrl_valid <= 1'b1;
                            o_state         <= ST_FIN_WAIT;
                        end
                    end
                    ST_FIN_WAIT: begin
                        // no TIME_WAIT so straight back to closed
                        if (i_rx_msg_valid && finack_ok) begin
                            o_tx_ctrl.flags <= FLAG_ACK;
                            o_tx_ctrl_valid <= 1'b1;
                            o_state         <= ST_CLOSED;
                        end
                    end
                endcase
            end
        end
    end

endmodule

// ==== tcp_stream.sv ====
`timescale 1ns/1ps

module tcp_stream #(
    parameter tcp_pkg::seq_num_t P_ISS    = 32'h0000_1000,
    parameter tcp_pkg::window_t  P_WINDOW = 16'hffff
) (
    input  logic                 i_clk,
    input  logic                 i_rst,

    input  logic                 i_enable,
    input  logic                 i_open,
    input  logic                 i_close,
    input  tcp_pkg::conn_cfg_t   i_cfg,
    output tcp_pkg::tcp_state_t  o_state,

    output tcp_pkg::word_t       o_tx_data,
    output logic                 o_tx_valid,
    output logic                 o_tx_last,
    output tcp_pkg::ip_meta_t    o_tx_meta,

    input  tcp_pkg::word_t       i_rx_data,
    input  logic                 i_rx_valid,
    input  logic                 i_rx_last
);

    import tcp_pkg::*;

    tx_ctrl_t   tx_ctrl;
    logic       tx_ctrl_valid;
    logic       tx_ctrl_ack;

    rx_msg_t    rx_msg;
    logic       rx_msg_valid;
    logic       rx_msg_ack;

    seq_num_t   w_tx_seq_number;
    seq_num_t   w_tx_ack_number;
    tcp_flags_t w_tx_flags;
    logic       w_tx_hdr_valid;
    logic       w_tx_packet_done;

    seq_num_t   w_rx_seq_number;
    seq_num_t   w_rx_ack_number;
    tcp_flags_t w_rx_flags;
    logic       w_rx_hdr_valid;

    tcp_state_manager #(
        .P_ISS                  (P_ISS)
    ) u_tcp_state_manager (
        .i_clk                  (i_clk),
        .i_rst                  (i_rst),
        .i_enable               (i_enable),
        .i_open                 (i_open),
        .i_close                (i_close),
        .o_tx_ctrl              (tx_ctrl),
        .o_tx_ctrl_valid        (tx_ctrl_valid),
        .i_tx_ctrl_ack          (tx_ctrl_ack),
        .i_rx_msg               (rx_msg),
        .i_rx_msg_valid         (rx_msg_valid),
        .o_rx_msg_ack           (rx_msg_ack),
        .o_state                (o_state)
    );

    tcp_tx_ctrl #(
        .P_ISS                  (P_ISS)
    ) u_tcp_tx_ctrl (
        .i_clk                  (i_clk),
        .i_rst                  (i_rst),
        .i_tx_ctrl              (tx_ctrl),
        .i_tx_ctrl_valid        (tx_ctrl_valid),
        .o_tx_ctrl_ack          (tx_ctrl_ack),
        .o_seq_number           (w_tx_seq_number),
        .o_flags                (w_tx_flags),
        .o_hdr_valid            (w_tx_hdr_valid),
        .i_packet_done          (w_tx_packet_done)
    );

    tcp_packet_generator #(
        .P_WINDOW               (P_WINDOW)
    ) u_tcp_packet_generator (
        .i_clk                  (i_clk),
        .i_rst                  (i_rst),
        .i_cfg                  (i_cfg),
        .i_seq_number           (w_tx_seq_number),
        .i_ack_number           (w_tx_ack_number),
        .i_flags                (w_tx_flags),
        .i_hdr_valid            (w_tx_hdr_valid),
        .o_packet_done          (w_tx_packet_done),
        .o_tx_data              (o_tx_data),
        .o_tx_valid             (o_tx_valid),
        .o_tx_last              (o_tx_last),
        .o_tx_meta              (o_tx_meta)
    );

    tcp_parser u_tcp_parser (
        .i_clk                  (i_clk),
        .i_rst                  (i_rst),
        .i_cfg                  (i_cfg),
        .i_rx_data              (i_rx_data),
        .i_rx_valid             (i_rx_valid),
        .i_rx_last              (i_rx_last),
        .o_seq_number           (w_rx_seq_number),
        .o_ack_number           (w_rx_ack_number),
        .o_flags                (w_rx_flags),
        .o_hdr_valid            (w_rx_hdr_valid)
    );

    tcp_rx_ctrl u_tcp_rx_ctrl (
        .i_clk                  (i_clk),
        .i_rst                  (i_rst),
        .i_seq_number           (w_rx_seq_number),
        .i_ack_number           (w_rx_ack_number),
        .i_flags                (w_rx_flags),
        .i_hdr_valid            (w_rx_hdr_valid),
        .o_rx_msg               (rx_msg),
        .o_rx_msg_valid         (rx_msg_valid),
        .i_rx_msg_ack           (rx_msg_ack),
        .o_ack_number           (w_tx_ack_number)
    );

endmodule

// ==== tcp_stream_tb.sv ====
`timescale 1ns/1ps

module tcp_stream_tb;

    import tcp_pkg::*;

    localparam seq_num_t ISS    = 32'h7a31_0c00;
    localparam window_t  WINDOW = 16'h2000;

    // watchdog budget covers reset plus a fixed length per test
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 5;
    localparam int TEST_CYCLES  = 400;
    localparam int MARGIN       = 200;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_TESTS * TEST_CYCLES + MARGIN) * 8;
    localparam int WAIT_LIMIT   = 64;

    localparam logic [2:0] LAST_WORD = 3'd4;

    typedef struct packed {
        logic [4:0][31:0] words;
        ip_meta_t         meta;
        logic             last_ok;
    } tx_seg_t;

    logic       clk;
    logic       rst;
    logic       rst_req;
    logic       enable;
    logic       open_cmd;
    logic       close_cmd;
    conn_cfg_t  cfg;
    tcp_state_t state;
    word_t      tx_data;
    logic       tx_valid;
    logic       tx_last;
    ip_meta_t   tx_meta;
    word_t      rx_data;
    logic       rx_valid;
    logic       rx_last;

    tx_seg_t    seg_q[$];
    tx_seg_t    cur_seg;
    logic [2:0] word_idx;
    int         rd_idx;
    logic [31:0] rng;

    tb_clk_gen #(
        .P_RST_CYCLES (RESET_CYCLES)
    ) u_clk_gen (
        .i_rst_req    (rst_req),
        .o_clk        (clk),
        .o_rst        (rst)
    );

    tcp_stream #(
        .P_ISS        (ISS),
        .P_WINDOW     (WINDOW)
    ) UUT (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_enable     (enable),
        .i_open       (open_cmd),
        .i_close      (close_cmd),
        .i_cfg        (cfg),
        .o_state      (state),
        .o_tx_data    (tx_data),
        .o_tx_valid   (tx_valid),
        .o_tx_last    (tx_last),
        .o_tx_meta    (tx_meta),
        .i_rx_data    (rx_data),
        .i_rx_valid   (rx_valid),
        .i_rx_last    (rx_last)
    );

    // collect transmitted segments
    always @(negedge clk) begin
        if (rst) begin
            word_idx = 3'd0;
        end else if (tx_valid) begin
            if (word_idx <= LAST_WORD) begin
                cur_seg.words[word_idx] = tx_data;
            end
            cur_seg.meta = tx_meta;
            if (tx_last) begin
                cur_seg.last_ok = (word_idx == LAST_WORD);
                seg_q.push_back(cur_seg);
                word_idx = 3'd0;
            end else if (word_idx != 3'd7) begin
                word_idx = word_idx + 3'd1;
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        assert (got == exp) else begin
            fail_now($sformatf("[ERROR] t=%0t %s: expected 0x%08h, got 0x%08h",
                               $time, what, exp, got));
        end
    endtask

    task automatic check_state(input string where, input tcp_state_t exp);
        assert (state == exp) else begin
            fail_now($sformatf("[ERROR] t=%0t %s: state expected %s, got %s",
                               $time, where, exp.name(), state.name()));
        end
    endtask

    task automatic check_segment(input string name, input tx_seg_t seg,
                                 input tcp_flags_t flags, input seq_num_t seq,
                                 input seq_num_t ack);
        ip_meta_t exp_meta;
        exp_meta.src_ip = cfg.src_ip;
        exp_meta.dst_ip = cfg.dst_ip;
        exp_meta.len    = 16'd20;
        check_word({name, " ports"}, seg.words[0], {cfg.src_port, cfg.dst_port});
        check_word({name, " seq"}, seg.words[1], seq);
        check_word({name, " ack"}, seg.words[2], ack);
        check_word({name, " offset/flags/window"}, seg.words[3], {4'd5, 4'd0, flags, WINDOW});
        check_word({name, " word 4"}, seg.words[4], 32'h0);
        assert (seg.meta == exp_meta) else begin
            fail_now($sformatf("[ERROR] t=%0t %s meta: expected 0x%020h, got 0x%020h",
                               $time, name, exp_meta, seg.meta));
        end
        assert (seg.last_ok) else begin
            fail_now($sformatf("[ERROR] t=%0t %s: last not on word 4", $time, name));
        end
    endtask

    task automatic wait_state(input tcp_state_t exp);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (state != exp && n < WAIT_LIMIT);
        if (state != exp) begin
            fail_now($sformatf("timed out waiting for state %s", exp.name()));
        end
    endtask

    task automatic wait_segment(output tx_seg_t seg);
        int n;
        n = 0;
        while (seg_q.size() <= rd_idx && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (seg_q.size() <= rd_idx) begin
            fail_now("timed out waiting for a transmitted segment");
        end else begin
            seg = seg_q[rd_idx];
            rd_idx++;
        end
    endtask

    // nothing may go out for the given window
    task automatic expect_quiet(input string where, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (!tx_valid) else begin
                fail_now($sformatf("[ERROR] t=%0t %s: unexpected transmit", $time, where));
            end
        end
        assert (seg_q.size() == rd_idx) else begin
            fail_now($sformatf("[ERROR] t=%0t %s: unexpected segment", $time, where));
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (rst && n < WAIT_LIMIT);
        if (rst) begin
            fail_now("reset never released");
        end
    endtask

    task automatic pulse_open();
        @(posedge clk);
        open_cmd <= 1'b1;
        @(posedge clk);
        open_cmd <= 1'b0;
    endtask

    task automatic pulse_close();
        @(posedge clk);
        close_cmd <= 1'b1;
        @(posedge clk);
        close_cmd <= 1'b0;
    endtask

    task automatic send_segment(input port_t sport, input port_t dport, input seq_num_t seq,
                                input seq_num_t ack, input tcp_flags_t flags);
        word_t w [5];
        w[0] = {sport, dport};
        w[1] = seq;
        w[2] = ack;
        w[3] = {4'd5, 4'd0, flags, 16'h1000};
        w[4] = 32'h0;
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            rx_data  <= w[i];
            rx_valid <= 1'b1;
            rx_last  <= (i == 4);
        end
        @(posedge clk);
        rx_valid <= 1'b0;
        rx_last  <= 1'b0;
    endtask

    // peer ports are ours swapped
    task automatic send_from_peer(input seq_num_t seq, input seq_num_t ack,
                                  input tcp_flags_t flags);
        send_segment(cfg.dst_port, cfg.src_port, seq, ack, flags);
    endtask

    task automatic test_reset_idle();
        wait_reset_release();
        check_state("after reset", ST_CLOSED);
        expect_quiet("after reset", 20);
    endtask

    task automatic test_active_open();
        tx_seg_t seg;
        pulse_open();
        wait_state(ST_SYN_SENT);
        wait_segment(seg);
        check_segment("SYN", seg, FLAG_SYN, ISS, 32'h0);
        expect_quiet("after SYN", 10);
    endtask

    task automatic test_handshake(input seq_num_t peer_iss);
        tx_seg_t seg;
        send_from_peer(peer_iss, ISS + 32'd5, FLAG_SYN | FLAG_ACK);
        expect_quiet("SYN+ACK wrong ack", 24);
        check_state("SYN+ACK wrong ack", ST_SYN_SENT);
        send_segment(cfg.dst_port + 16'd1, cfg.src_port, peer_iss, ISS + 32'd1,
                     FLAG_SYN | FLAG_ACK);
        expect_quiet("SYN+ACK wrong port", 24);
        check_state("SYN+ACK wrong port", ST_SYN_SENT);
        send_segment(cfg.dst_port, cfg.src_port + 16'd1, peer_iss, ISS + 32'd1,
                     FLAG_SYN | FLAG_ACK);
        expect_quiet("SYN+ACK wrong local port", 24);
        check_state("SYN+ACK wrong local port", ST_SYN_SENT);
        send_from_peer(peer_iss, ISS + 32'd1, FLAG_SYN | FLAG_ACK);
        wait_state(ST_ESTABLISHED);
        wait_segment(seg);
        check_segment("handshake ACK", seg, FLAG_ACK, ISS + 32'd1, peer_iss + 32'd1);
        expect_quiet("after handshake", 10);
    endtask

    task automatic test_active_close(input seq_num_t peer_iss);
        tx_seg_t seg;
        pulse_close();
        wait_state(ST_FIN_WAIT);
        wait_segment(seg);
        check_segment("FIN+ACK", seg, FLAG_FIN | FLAG_ACK, ISS + 32'd1, peer_iss + 32'd1);
        send_from_peer(peer_iss + 32'd1, ISS + 32'd2, FLAG_FIN | FLAG_ACK);
        wait_state(ST_CLOSED);
        wait_segment(seg);
        check_segment("close ACK", seg, FLAG_ACK, ISS + 32'd2, peer_iss + 32'd2);
        expect_quiet("after close", 10);
    endtask

    task automatic test_abort(input seq_num_t peer_iss);
        tx_seg_t seg;
        @(posedge clk);
        rst_req <= 1'b1;
        @(posedge clk);
        rst_req <= 1'b0;
        wait_reset_release();
        check_state("second reset", ST_CLOSED);
        pulse_open();
        wait_state(ST_SYN_SENT);
        wait_segment(seg);
        check_segment("reopen SYN", seg, FLAG_SYN, ISS, 32'h0);
        send_from_peer(peer_iss, ISS + 32'd1, FLAG_SYN | FLAG_ACK);
        wait_state(ST_ESTABLISHED);
        wait_segment(seg);
        check_segment("reopen ACK", seg, FLAG_ACK, ISS + 32'd1, peer_iss + 32'd1);
        // peer abort
        send_from_peer(peer_iss + 32'd1, 32'h0, FLAG_RST);
        wait_state(ST_CLOSED);
        expect_quiet("after RST", 24);
        @(posedge clk);
        enable <= 1'b0;
        pulse_open();
        expect_quiet("open while disabled", 24);
        check_state("open while disabled", ST_CLOSED);
        @(posedge clk);
        enable <= 1'b1;
        expect_quiet("enable restored", 8);
        check_state("enable restored", ST_CLOSED);
        // rcv_nxt is nonzero here, a SYN still carries ack 0
        pulse_open();
        wait_state(ST_SYN_SENT);
        wait_segment(seg);
        check_segment("SYN after RST", seg, FLAG_SYN, ISS + 32'd1, 32'h0);
    endtask

    initial begin
        #(TIMEOUT_NS);
        fail_now("watchdog timeout, tests did not finish in time");
    end

    initial begin
        seq_num_t peer_iss;
        seq_num_t peer_iss2;
        rst_req      = 1'b0;
        enable       = 1'b1;
        open_cmd     = 1'b0;
        close_cmd    = 1'b0;
        cfg.src_ip   = 32'hc0a8_0a01;
        cfg.dst_ip   = 32'hc0a8_0a02;
        cfg.src_port = 16'hc351;
        cfg.dst_port = 16'h0050;
        rx_data      = 32'h0;
        rx_valid     = 1'b0;
        rx_last      = 1'b0;
        rd_idx       = 0;
        rng          = 32'd33988;
        rng          = xorshift32(rng);
        peer_iss     = rng;
        rng          = xorshift32(rng);
        peer_iss2    = rng;

        test_reset_idle();
        test_active_open();
        test_handshake(peer_iss);
        test_active_close(peer_iss);
        test_abort(peer_iss2);

        $display("Test OK");
        $finish;
    end

endmodule

// ==== tcp_tx_ctrl.sv ====
`timescale 1ns/1ps

module tcp_tx_ctrl #(
    parameter tcp_pkg::seq_num_t P_ISS = 32'h0000_1000
) (
    input  logic                 i_clk,
    input  logic                 i_rst,

    input  tcp_pkg::tx_ctrl_t    i_tx_ctrl,
    input  logic                 i_tx_ctrl_valid,
    output logic                 o_tx_ctrl_ack,

    output tcp_pkg::seq_num_t    o_seq_number,
    output tcp_pkg::tcp_flags_t  o_flags,
    output logic                 o_hdr_valid,

    input  logic                 i_packet_done
);

    import tcp_pkg::*;

    seq_num_t snd_nxt;
    logic     busy;
    logic     take;
    logic     consumes_seq;

    assign take         = i_tx_ctrl_valid && !busy;
    // SYN and FIN each occupy one sequence number
    assign consumes_seq = (i_tx_ctrl.flags & (FLAG_SYN | FLAG_FIN)) != '0;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            snd_nxt       <= P_ISS;
            busy          <= 1'b0;
            o_tx_ctrl_ack <= 1'b0;
            o_hdr_valid   <= 1'b0;
        end else begin
            o_tx_ctrl_ack <= take;
            o_hdr_valid   <= take;
            if (take) begin
                busy <= 1'b1;
                if (consumes_seq) begin
                    snd_nxt <= snd_nxt + 32'd1;
                end
            end else if (i_packet_done) begin
                busy <= 1'b0;
            end
        end
    end

    // header fields for the generator
    always_ff @(posedge i_clk) begin
        if (take) begin
            o_seq_number <= snd_nxt;
            o_flags      <= i_tx_ctrl.flags;
        end
    end

endmodule
